/* hw/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    localparam int fetch_width      = 2;
    localparam int commit_width     = 4;
    localparam int arch_regs        = 32;
    localparam int areg_width       = 5;
    localparam int preg_width       = 6;
    localparam int commit_idx_width = 2;

    // one rename group, every field indexed by fetch slot
    typedef struct packed {
        logic [fetch_width-1:0][areg_width-1:0] vrs1;
        logic [fetch_width-1:0][areg_width-1:0] vrs2;
        logic [fetch_width-1:0]                 we;
        logic [fetch_width-1:0][areg_width-1:0] vrd;
        logic [fetch_width-1:0][preg_width-1:0] prd;
    } rename_req_t;

    // old_prd_spec goes to the reorder buffer so it can undo the mapping on a flush
    typedef struct packed {
        logic [fetch_width-1:0][preg_width-1:0] prs1;
        logic [fetch_width-1:0][preg_width-1:0] prs2;
        logic [fetch_width-1:0][preg_width-1:0] old_prd_spec;
    } rename_rsp_t;

    typedef struct packed {
        logic [commit_width-1:0]                 en;
        logic [commit_width-1:0]                 we;
        logic [commit_width-1:0][areg_width-1:0] vrd;
        logic [commit_width-1:0][preg_width-1:0] prd;
    } commit_bus_t;

    typedef struct packed {
        logic                                   walk;
        logic [fetch_width-1:0]                 we;
        logic [fetch_width-1:0][areg_width-1:0] vrd;
        logic [fetch_width-1:0][preg_width-1:0] prd;
    } walk_bus_t;

    typedef struct packed {
        logic [commit_width-1:0][preg_width-1:0] old_prd;
    } commit_rsp_t;

endpackage

`default_nettype wire

/* hw/rat_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module rat_bank #(
    parameter int n_read  = 2,
    parameter int n_write = 2
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [n_read-1:0][rename_pkg::areg_width-1:0]  raddr,
    output logic [n_read-1:0][rename_pkg::preg_width-1:0]  rdata,
    input  logic [n_write-1:0]                             we,
    input  logic [n_write-1:0][rename_pkg::areg_width-1:0] waddr,
    input  logic [n_write-1:0][rename_pkg::preg_width-1:0] wdata
);

    import rename_pkg::*;

    logic [preg_width-1:0] map [arch_regs];

    // reads see the table as it stood before this cycle's writes
    for (genvar r = 0; r < n_read; r++) begin : g_read
        assign rdata[r] = map[raddr[r]];
    end

    // slots are applied in ascending order so the highest slot wins a shared address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= preg_width'(i);
            end
        end else begin
            for (int w = 0; w < n_write; w++) begin
                if (we[w]) begin
                    map[waddr[w]] <= wdata[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/commit_waw_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_waw_resolver (
    input  rename_pkg::commit_bus_t                                        commit,
    input  logic [rename_pkg::commit_width-1:0][rename_pkg::preg_width-1:0] map_old,
    output logic [rename_pkg::commit_width-1:0]                            commit_we,
    output rename_pkg::commit_rsp_t                                        rsp
);

    import rename_pkg::*;

    logic [commit_width-1:0]                       slot_we;
    logic [commit_width-1:0][commit_width-1:0]     same_vrd;
    logic [commit_width-1:0][commit_width-1:0]     older_hit;
    logic [commit_width-1:0][commit_width-1:0]     younger_hit;
    logic [commit_width-1:0]                       has_older;
    logic [commit_width-1:0][commit_idx_width-1:0] older_idx;

    assign slot_we = commit.en & commit.we;

    // same_vrd[i][j] is set when slot j writes the register that slot i names
    always_comb begin
        for (int i = 0; i < commit_width; i++) begin
            for (int j = 0; j < commit_width; j++) begin
                same_vrd[i][j] = (i != j) && slot_we[j] && (commit.vrd[i] == commit.vrd[j]);
                older_hit[i][j]   = same_vrd[i][j] && (j < i);
                younger_hit[i][j] = same_vrd[i][j] && (j > i);
            end
        end
    end

    // priority search for the nearest older writer, scanning upward so the last hit wins
    always_comb begin
        for (int i = 0; i < commit_width; i++) begin
            has_older[i] = 1'b0;
            older_idx[i] = '0;
            for (int j = 0; j < commit_width; j++) begin
                if (older_hit[i][j]) begin
                    has_older[i] = 1'b1;
                    older_idx[i] = commit_idx_width'(j);
                end
            end
        end
    end

    // the released register is the one this group just mapped, else the committed entry
    always_comb begin
        for (int i = 0; i < commit_width; i++) begin
            if (has_older[i]) begin
                rsp.old_prd[i] = commit.prd[older_idx[i]];
            end else begin
                rsp.old_prd[i] = map_old[i];
            end
        end
    end

    // a younger writer to the same register makes this write dead
    always_comb begin
        for (int i = 0; i < commit_width; i++) begin
            commit_we[i] = slot_we[i] && !(|younger_hit[i]);
        end
    end

endmodule

`default_nettype wire

/* hw/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_table (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  rename_pkg::rename_req_t                                       req,
    input  rename_pkg::commit_bus_t                                       commit,
    input  rename_pkg::walk_bus_t                                         walk,
    output logic [rename_pkg::fetch_width-1:0][rename_pkg::preg_width-1:0] raw_prs1,
    output logic [rename_pkg::fetch_width-1:0][rename_pkg::preg_width-1:0] raw_prs2,
    output logic [rename_pkg::fetch_width-1:0][rename_pkg::preg_width-1:0] raw_old_prd,
    output rename_pkg::commit_rsp_t                                       commit_rsp
);

    import rename_pkg::*;

    logic [fetch_width-1:0]                   spec_we;
    logic [fetch_width-1:0][areg_width-1:0]   spec_waddr;
    logic [fetch_width-1:0][preg_width-1:0]   spec_wdata;
    logic [2*fetch_width-1:0][areg_width-1:0] rs1_raddr;
    logic [2*fetch_width-1:0][preg_width-1:0] rs1_rdata;
    logic [commit_width-1:0]                  commit_we;
    logic [commit_width-1:0][preg_width-1:0]  map_old;

    // a recovery walk owns the speculative write ports
    assign spec_we    = walk.walk ? walk.we  : req.we;
    assign spec_waddr = walk.walk ? walk.vrd : req.vrd;
    assign spec_wdata = walk.walk ? walk.prd : req.prd;

    // lower read group serves rs1, upper group looks up the destination's current mapping
    assign rs1_raddr   = {req.vrd, req.vrs1};
    assign raw_prs1    = rs1_rdata[fetch_width-1:0];
    assign raw_old_prd = rs1_rdata[2*fetch_width-1:fetch_width];

    rat_bank #(.n_read(2 * fetch_width), .n_write(fetch_width)) rs1_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (rs1_raddr),
        .rdata (rs1_rdata),
        .we    (spec_we),
        .waddr (spec_waddr),
        .wdata (spec_wdata)
    );

    rat_bank #(.n_read(fetch_width), .n_write(fetch_width)) rs2_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (req.vrs2),
        .rdata (raw_prs2),
        .we    (spec_we),
        .waddr (spec_waddr),
        .wdata (spec_wdata)
    );

    rat_bank #(.n_read(commit_width), .n_write(commit_width)) commit_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (commit.vrd),
        .rdata (map_old),
        .we    (commit_we),
        .waddr (commit.vrd),
        .wdata (commit.prd)
    );

    commit_waw_resolver u_waw (
        .commit    (commit),
        .map_old   (map_old),
        .commit_we (commit_we),
        .rsp       (commit_rsp)
    );

endmodule

`default_nettype wire

/* hw/intra_group_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module intra_group_bypass (
    input  rename_pkg::rename_req_t                                       req,
    input  logic [rename_pkg::fetch_width-1:0][rename_pkg::preg_width-1:0] raw_prs1,
    input  logic [rename_pkg::fetch_width-1:0][rename_pkg::preg_width-1:0] raw_prs2,
    input  logic [rename_pkg::fetch_width-1:0][rename_pkg::preg_width-1:0] raw_old_prd,
    output rename_pkg::rename_rsp_t                                       rsp
);

    import rename_pkg::*;

    // older slots are scanned in ascending order so the nearest one lands last
    always_comb begin
        for (int k = 0; k < fetch_width; k++) begin
            rsp.prs1[k]         = raw_prs1[k];
            rsp.prs2[k]         = raw_prs2[k];
            rsp.old_prd_spec[k] = raw_old_prd[k];
            for (int m = 0; m < k; m++) begin
                if (req.we[m]) begin
                    if (req.vrd[m] == req.vrs1[k]) begin
                        rsp.prs1[k] = req.prd[m];
                    end
                    if (req.vrd[m] == req.vrs2[k]) begin
                        rsp.prs2[k] = req.prd[m];
                    end
                    // the table has not yet seen the older slot's write to this register
                    if (req.vrd[m] == req.vrd[k]) begin
                        rsp.old_prd_spec[k] = req.prd[m];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rename_pkg::rename_req_t req,
    input  rename_pkg::commit_bus_t commit,
    input  rename_pkg::walk_bus_t   walk,
    output rename_pkg::rename_rsp_t rsp,
    output rename_pkg::commit_rsp_t commit_rsp
);

    import rename_pkg::*;

    logic [fetch_width-1:0][preg_width-1:0] raw_prs1;
    logic [fetch_width-1:0][preg_width-1:0] raw_prs2;
    logic [fetch_width-1:0][preg_width-1:0] raw_old_prd;

    rename_table u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .commit      (commit),
        .walk        (walk),
        .raw_prs1    (raw_prs1),
        .raw_prs2    (raw_prs2),
        .raw_old_prd (raw_old_prd),
        .commit_rsp  (commit_rsp)
    );

    intra_group_bypass u_bypass (
        .req         (req),
        .raw_prs1    (raw_prs1),
        .raw_prs2    (raw_prs2),
        .raw_old_prd (raw_old_prd),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

/* sim/rename_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_checker (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  rename_pkg::commit_bus_t               commit,
    input  rename_pkg::walk_bus_t                 walk,
    input  logic [rename_pkg::commit_width-1:0]   commit_we,
    input  logic [rename_pkg::fetch_width-1:0]    spec_we,
    input  rename_pkg::commit_rsp_t               commit_rsp
);

    import rename_pkg::*;

    logic we_clash;

    // any pair of surviving commit writes aimed at one register
    always_comb begin
        we_clash = 1'b0;
        for (int i = 0; i < commit_width; i++) begin
            for (int j = i + 1; j < commit_width; j++) begin
                if (commit_we[i] && commit_we[j] && (commit.vrd[i] == commit.vrd[j])) begin
                    we_clash = 1'b1;
                end
            end
        end
    end

    a_commit_unique: assert property (@(posedge clk) disable iff (!rst_n) !we_clash)
        else $error("two surviving commit writes target the same register");

    a_walk_owns_spec: assert property (@(posedge clk) disable iff (!rst_n)
        walk.walk |-> (spec_we == walk.we))
        else $error("speculative write enables differ from the walk bus during a walk");

    for (genvar i = 0; i < commit_width; i++) begin : g_old_prd
        a_old_prd_known: assert property (@(posedge clk) disable iff (!rst_n)
            commit.en[i] |-> !$isunknown(commit_rsp.old_prd[i]))
            else $error("old_prd has unknown bits on an enabled commit slot");
    end

endmodule

bind rename_table rename_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit     (commit),
    .walk       (walk),
    .commit_we  (commit_we),
    .spec_we    (spec_we),
    .commit_rsp (commit_rsp)
);

`default_nettype wire

/* sim/tb_rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_stage;

    import rename_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int n_cycles     = 2000;
    localparam int n_random     = 1940;

    logic        clk;
    logic        rst_n;
    rename_req_t req;
    commit_bus_t commit;
    walk_bus_t   walk;
    rename_rsp_t rsp;
    commit_rsp_t commit_rsp;

    // reference copies of the speculative and committed maps
    logic [preg_width-1:0] spec_map   [arch_regs];
    logic [preg_width-1:0] commit_map [arch_regs];

    rename_rsp_t exp_rsp;
    commit_rsp_t exp_commit_rsp;
    logic        check_en;
    logic [31:0] rand_state;
    int          n_checks;
    int          rename_errors;
    int          commit_errors;

    rename_stage UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .commit     (commit),
        .walk       (walk),
        .rsp        (rsp),
        .commit_rsp (commit_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw();
        rand_state = lcg_step(rand_state);
        return rand_state;
    endfunction

    // expected rename answer: table lookup, then the nearest older slot in the group
    function automatic rename_rsp_t predict_rename(input rename_req_t q);
        rename_rsp_t p;
        logic        found1;
        logic        found2;
        logic        found_old;
        for (int k = 0; k < fetch_width; k++) begin
            p.prs1[k]         = spec_map[q.vrs1[k]];
            p.prs2[k]         = spec_map[q.vrs2[k]];
            p.old_prd_spec[k] = spec_map[q.vrd[k]];
            found1    = 1'b0;
            found2    = 1'b0;
            found_old = 1'b0;
            for (int m = k - 1; m >= 0; m--) begin
                if (q.we[m] && !found1 && (q.vrd[m] == q.vrs1[k])) begin
                    p.prs1[k] = q.prd[m];
                    found1    = 1'b1;
                end
                if (q.we[m] && !found2 && (q.vrd[m] == q.vrs2[k])) begin
                    p.prs2[k] = q.prd[m];
                    found2    = 1'b1;
                end
                if (q.we[m] && !found_old && (q.vrd[m] == q.vrd[k])) begin
                    p.old_prd_spec[k] = q.prd[m];
                    found_old         = 1'b1;
                end
            end
        end
        return p;
    endfunction

    // expected released register: nearest earlier writer in the group, else committed map
    function automatic commit_rsp_t predict_commit(input commit_bus_t c);
        commit_rsp_t p;
        logic        found;
        for (int i = 0; i < commit_width; i++) begin
            p.old_prd[i] = commit_map[c.vrd[i]];
            found        = 1'b0;
            for (int j = i - 1; j >= 0; j--) begin
                if (!found && c.en[j] && c.we[j] && (c.vrd[j] == c.vrd[i])) begin
                    p.old_prd[i] = c.prd[j];
                    found        = 1'b1;
                end
            end
        end
        return p;
    endfunction

    // the model follows the write rules, ascending slots so the youngest write lands
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < arch_regs; a++) begin
                spec_map[a]   = preg_width'(a);
                commit_map[a] = preg_width'(a);
            end
        end else begin
            for (int w = 0; w < fetch_width; w++) begin
                if (walk.walk && walk.we[w]) begin
                    spec_map[walk.vrd[w]] = walk.prd[w];
                end else if (!walk.walk && req.we[w]) begin
                    spec_map[req.vrd[w]] = req.prd[w];
                end
            end
            for (int i = 0; i < commit_width; i++) begin
                if (commit.en[i] && commit.we[i]) begin
                    commit_map[commit.vrd[i]] = commit.prd[i];
                end
            end
        end
    end

    task automatic check_field(input string what, input int slot,
                               input logic [preg_width-1:0] expected,
                               input logic [preg_width-1:0] actual, input bit commit_side);
        n_checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: slot %0d %s expected %0d got %0d",
                     $time, slot, what, expected, actual);
            if (commit_side) begin
                commit_errors++;
            end else begin
                rename_errors++;
            end
        end
    endtask

    // outputs are combinational, so they are settled well before the rising edge
    initial begin
        forever begin
            @(negedge clk);
            #15;
            if (check_en) begin
                for (int k = 0; k < fetch_width; k++) begin
                    check_field("prs1", k, exp_rsp.prs1[k], rsp.prs1[k], 1'b0);
                    check_field("prs2", k, exp_rsp.prs2[k], rsp.prs2[k], 1'b0);
                    check_field("old_prd_spec", k, exp_rsp.old_prd_spec[k],
                                rsp.old_prd_spec[k], 1'b0);
                end
                for (int i = 0; i < commit_width; i++) begin
                    if (commit.en[i]) begin
                        check_field("old_prd", i, exp_commit_rsp.old_prd[i],
                                    commit_rsp.old_prd[i], 1'b1);
                    end
                end
            end
        end
    end

    task automatic apply(input rename_req_t q, input commit_bus_t c, input walk_bus_t w);
        @(negedge clk);
        req            = q;
        commit         = c;
        walk           = w;
        exp_rsp        = predict_rename(q);
        exp_commit_rsp = predict_commit(c);
        check_en       = 1'b1;
    endtask

    initial begin
        #((n_cycles + 20) * clk_period);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rename_req_t q;
        commit_bus_t cb;
        walk_bus_t   wb;
        logic [31:0] r;
        rst_n         = 1'b0;
        req           = '0;
        commit        = '0;
        walk          = '0;
        check_en      = 1'b0;
        rand_state    = 32'h4608f6cb;
        n_checks      = 0;
        rename_errors = 0;
        commit_errors = 0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        // sweep every register through the ports while the maps are still identity
        for (int c = 0; c < 16; c++) begin
            q         = '0;
            q.vrs1[0] = areg_width'(2 * c);
            q.vrs1[1] = areg_width'(2 * c + 1);
            q.vrs2[0] = areg_width'(31 - 2 * c);
            q.vrs2[1] = areg_width'(30 - 2 * c);
            q.vrd[0]  = areg_width'(c);
            q.vrd[1]  = areg_width'(c + 16);
            cb        = '0;
            cb.en     = 4'hf;
            for (int i = 0; i < commit_width; i++) begin
                cb.vrd[i] = areg_width'(4 * c + i);
            end
            apply(q, cb, '0);
        end

        // two writes to one register in a group, slot 1 bypassing from slot 0
        q         = '0;
        q.we      = 2'b11;
        q.vrd[0]  = 5'd3;
        q.prd[0]  = 6'd40;
        q.vrs1[1] = 5'd3;
        q.vrs2[1] = 5'd3;
        q.vrd[1]  = 5'd3;
        q.prd[1]  = 6'd41;
        apply(q, '0, '0);
        q    = '0;
        q.vrs1 = {5'd3, 5'd3};
        q.vrs2 = {5'd3, 5'd3};
        q.vrd  = {5'd3, 5'd3};
        apply(q, '0, '0);

        // walk slot 0 restores register 3 while rename tries to write it
        q          = '0;
        q.we       = 2'b11;
        q.vrd      = {5'd3, 5'd3};
        q.prd      = {6'd61, 6'd60};
        wb         = '0;
        wb.walk    = 1'b1;
        wb.we      = 2'b01;
        wb.vrd[0]  = 5'd3;
        wb.prd[0]  = 6'd50;
        apply(q, '0, wb);
        q      = '0;
        q.vrs1 = {5'd3, 5'd3};
        q.vrs2 = {5'd3, 5'd3};
        q.vrd  = {5'd3, 5'd3};
        apply(q, '0, '0);

        // four commits to one register, then a lookup of what survived
        cb     = '0;
        cb.en  = 4'hf;
        cb.we  = 4'hf;
        cb.vrd = {5'd5, 5'd5, 5'd5, 5'd5};
        cb.prd = {6'd13, 6'd12, 6'd11, 6'd10};
        apply('0, cb, '0);
        cb        = '0;
        cb.en     = 4'b0001;
        cb.vrd[0] = 5'd5;
        apply('0, cb, '0);

        for (int n = 0; n < n_random; n++) begin
            for (int k = 0; k < fetch_width; k++) begin
                r         = draw();
                q.vrs1[k] = {2'b00, r[18:16]};
                q.vrs2[k] = {2'b00, r[21:19]};
                q.vrd[k]  = {2'b00, r[24:22]};
                q.we[k]   = r[25];
                q.prd[k]  = r[31:26];
                r          = draw();
                wb.we[k]   = r[16];
                wb.vrd[k]  = {2'b00, r[19:17]};
                wb.prd[k]  = r[25:20];
            end
            for (int i = 0; i < commit_width; i++) begin
                r          = draw();
                cb.en[i]   = r[16] | r[17];
                cb.we[i]   = r[18] | r[19];
                cb.vrd[i]  = {2'b00, r[22:20]};
                cb.prd[i]  = r[28:23];
            end
            r       = draw();
            wb.walk = (r[31:29] == 3'd0);
            apply(q, cb, wb);
        end

        @(posedge clk);
        $display("checks: %0d, rename errors: %0d, commit errors: %0d",
                 n_checks, rename_errors, commit_errors);
        if (rename_errors + commit_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/rename_pkg.sv
hw/rat_bank.sv
hw/commit_waw_resolver.sv
hw/rename_table.sv
hw/intra_group_bypass.sv
hw/rename_stage.sv
sim/rename_checker.sv
sim/tb_rename_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rename_stage
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
